// File: common/mem_pkg.sv
package mem_pkg;

    // cpu side
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int MASK_W = WORD_W / 8;    // byte enables per word

    // line side
    localparam int LINE_W = 256;
    localparam int OFFSET_W = $clog2(LINE_W / 8);    // byte offset in a line

    // external bus
    localparam int BURST_W = 64;
    localparam int BURSTS_PER_LINE = LINE_W / BURST_W;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [BURST_W-1:0] burst_t;

endpackage

// File: cache/cache_arrays.sv
`timescale 1ns/1ps

module cache_arrays #(
    parameter int INDEX_W = 3
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic [INDEX_W-1:0]                                    idx_i,
    input  logic [mem_pkg::ADDR_W-mem_pkg::OFFSET_W-INDEX_W-1:0] tag_i,
    input  mem_pkg::line_t                                        line_i,
    input  logic [mem_pkg::LINE_W/8-1:0]                          line_mask_i,
    input  logic                                                  write_line_i,
    input  logic                                                  set_valid_i,
    input  logic                                                  set_dirty_i,
    input  logic                                                  clear_dirty_i,
    output logic [mem_pkg::ADDR_W-mem_pkg::OFFSET_W-INDEX_W-1:0] tag_o,
    output logic                                                  valid_o,
    output logic                                                  dirty_o,
    output mem_pkg::line_t                                        line_o
);
    import mem_pkg::*;

    localparam int SETS = 2 ** INDEX_W;
    localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;
    localparam int BYTES = LINE_W / 8;

    logic [TAG_W-1:0] tag_mem [SETS];
    line_t            data_mem [SETS];
    logic [SETS-1:0]  valid_q;
    logic [SETS-1:0]  dirty_q;

    // read port is asynchronous on the index
    assign tag_o   = tag_mem[idx_i];
    assign valid_o = valid_q[idx_i];
    assign dirty_o = dirty_q[idx_i];
    assign line_o  = data_mem[idx_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (set_valid_i) begin
                valid_q[idx_i] <= 1'b1;
            end
            if (set_dirty_i) begin
                dirty_q[idx_i] <= 1'b1;
            end else if (clear_dirty_i) begin    // set wins over clear
                dirty_q[idx_i] <= 1'b0;
            end
        end
    end

    // tag is only written together with a fill
    always_ff @(posedge clk) begin
        if (set_valid_i) begin
            tag_mem[idx_i] <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES; b++) begin
            if (write_line_i && line_mask_i[b]) begin
                data_mem[idx_i][b*8 +: 8] <= line_i[b*8 +: 8];
            end
        end
    end

endmodule

// File: cache/l1_cache.sv
`timescale 1ns/1ps

module l1_cache #(
    parameter int INDEX_W = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       mem_read_i,
    input  logic                       mem_write_i,
    input  mem_pkg::addr_t             mem_addr_i,
    input  logic [mem_pkg::MASK_W-1:0] mem_wmask_i,
    input  mem_pkg::word_t             mem_wdata_i,
    output mem_pkg::word_t             mem_rdata_o,
    output logic                       mem_resp_o,
    output logic                       pmem_read_o,
    output logic                       pmem_write_o,
    output mem_pkg::addr_t             pmem_addr_o,
    output mem_pkg::line_t             pmem_wdata_o,
    input  mem_pkg::line_t             pmem_rdata_i,
    input  logic                       pmem_resp_i
);
    import mem_pkg::*;

    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WORDS = LINE_W / WORD_W;
    localparam int SEL_W = $clog2(WORDS);
    localparam int BYTE_W = $clog2(MASK_W);
    localparam int LMASK_W = LINE_W / 8;

    typedef enum logic [1:0] {
        S_IDLE,         // compare tag, serve hits
        S_WRITEBACK,
        S_FILL
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [TAG_W-1:0]   addr_tag;
    logic [INDEX_W-1:0] addr_idx;
    logic [SEL_W-1:0]   addr_sel;
    logic [TAG_W-1:0]   way_tag;
    logic               way_valid;
    logic               way_dirty;
    line_t              way_line;
    line_t              wr_line;
    logic [LMASK_W-1:0] wr_mask;
    logic               wr_en;
    logic               set_valid;
    logic               set_dirty;
    logic               clear_dirty;
    logic               req;
    logic               hit;
    logic               resp_q;
    word_t              rdata_q;

    assign addr_tag = mem_addr_i[ADDR_W-1 -: TAG_W];
    assign addr_idx = mem_addr_i[OFFSET_W +: INDEX_W];
    assign addr_sel = mem_addr_i[BYTE_W +: SEL_W];    // word within the line

    // request is still held during its resp cycle
    assign req = (mem_read_i || mem_write_i) && !resp_q;
    assign hit = way_valid && (way_tag == addr_tag);

    cache_arrays #(
        .INDEX_W(INDEX_W)
    ) arrays (
        .clk          (clk),
        .rst          (rst),
        .idx_i        (addr_idx),
        .tag_i        (addr_tag),
        .line_i       (wr_line),
        .line_mask_i  (wr_mask),
        .write_line_i (wr_en),
        .set_valid_i  (set_valid),
        .set_dirty_i  (set_dirty),
        .clear_dirty_i(clear_dirty),
        .tag_o        (way_tag),
        .valid_o      (way_valid),
        .dirty_o      (way_dirty),
        .line_o       (way_line)
    );

    always_comb begin
        state_d = state_q;
        wr_en = 1'b0;
        wr_line = {WORDS{mem_wdata_i}};    // word copied to every slot
        wr_mask = '0;
        set_valid = 1'b0;
        set_dirty = 1'b0;
        clear_dirty = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (req && hit && mem_write_i) begin
                    wr_en = 1'b1;
                    wr_mask = LMASK_W'(mem_wmask_i) << (MASK_W * addr_sel);
                    set_dirty = 1'b1;
                end else if (req && !hit) begin
                    state_d = (way_valid && way_dirty) ? S_WRITEBACK : S_FILL;
                end
            end
            S_WRITEBACK: begin
                if (pmem_resp_i) begin
                    clear_dirty = 1'b1;
                    state_d = S_FILL;
                end
            end
            S_FILL: begin
                if (pmem_resp_i) begin
                    wr_en = 1'b1;
                    wr_line = pmem_rdata_i;
                    wr_mask = '1;
                    set_valid = 1'b1;
                    state_d = S_IDLE;    // retried as a hit
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            resp_q <= 1'b0;
        end else begin
            state_q <= state_d;
            resp_q <= (state_q == S_IDLE) && req && hit;
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && req && hit) begin
            rdata_q <= way_line[addr_sel*WORD_W +: WORD_W];
        end
    end

    assign mem_resp_o = resp_q;
    assign mem_rdata_o = rdata_q;

    assign pmem_read_o = (state_q == S_FILL);
    assign pmem_write_o = (state_q == S_WRITEBACK);
    assign pmem_wdata_o = way_line;
    // victim address during writeback, requested line otherwise
    assign pmem_addr_o = (state_q == S_WRITEBACK) ? {way_tag, addr_idx, {OFFSET_W{1'b0}}}
                                                  : {addr_tag, addr_idx, {OFFSET_W{1'b0}}};

    // resp only answers a request the requester still holds
    resp_needs_req: assert property (@(posedge clk) disable iff (rst)
        mem_resp_o |-> (mem_read_i || mem_write_i));

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           a_read_i,
    input  logic           a_write_i,
    input  mem_pkg::addr_t a_addr_i,
    input  mem_pkg::line_t a_wdata_i,
    output mem_pkg::line_t a_rdata_o,
    output logic           a_resp_o,
    input  logic           b_read_i,
    input  logic           b_write_i,
    input  mem_pkg::addr_t b_addr_i,
    input  mem_pkg::line_t b_wdata_i,
    output mem_pkg::line_t b_rdata_o,
    output logic           b_resp_o,
    output logic           pmem_read_o,
    output logic           pmem_write_o,
    output mem_pkg::addr_t pmem_addr_o,
    output mem_pkg::line_t pmem_wdata_o,
    input  mem_pkg::line_t pmem_rdata_i,
    input  logic           pmem_resp_i
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_A,
        OWN_B
    } owner_e;

    owner_e owner_q;
    logic   a_req;
    logic   b_req;
    line_t  rdata_q;

    // a port in its resp cycle still shows the old request
    assign a_req = (a_read_i || a_write_i) && !a_resp_o;
    assign b_req = (b_read_i || b_write_i) && !b_resp_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner_q <= OWN_NONE;
            pmem_read_o <= 1'b0;
            pmem_write_o <= 1'b0;
            a_resp_o <= 1'b0;
            b_resp_o <= 1'b0;
        end else begin
            a_resp_o <= 1'b0;    // single cycle pulse
            b_resp_o <= 1'b0;
            case (owner_q)
                OWN_NONE: begin
                    if (b_req) begin    // b wins a tie
                        owner_q <= OWN_B;
                        pmem_read_o <= b_read_i;
                        pmem_write_o <= b_write_i;
                    end else if (a_req) begin
                        owner_q <= OWN_A;
                        pmem_read_o <= a_read_i;
                        pmem_write_o <= a_write_i;
                    end
                end
                default: begin
                    if (pmem_resp_i) begin
                        owner_q <= OWN_NONE;
                        pmem_read_o <= 1'b0;
                        pmem_write_o <= 1'b0;
                        a_resp_o <= (owner_q == OWN_A);
                        b_resp_o <= (owner_q == OWN_B);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (owner_q == OWN_NONE) begin
            if (b_req) begin
                pmem_addr_o <= b_addr_i;
                pmem_wdata_o <= b_wdata_i;
            end else if (a_req) begin
                pmem_addr_o <= a_addr_i;
                pmem_wdata_o <= a_wdata_i;
            end
        end else if (pmem_resp_i) begin
            rdata_q <= pmem_rdata_i;
        end
    end

    // data is shared, resp tells which side it belongs to
    assign a_rdata_o = rdata_q;
    assign b_rdata_o = rdata_q;

    // the owning cache holds its request until resp
    a_owner_holds: assert property (@(posedge clk) disable iff (rst)
        (owner_q == OWN_A) |-> (a_read_i || a_write_i));
    b_owner_holds: assert property (@(posedge clk) disable iff (rst)
        (owner_q == OWN_B) |-> (b_read_i || b_write_i));

endmodule

// File: hw/cacheline_adaptor.sv
`timescale 1ns/1ps

module cacheline_adaptor (
    input  logic            clk,
    input  logic            rst,
    input  logic            read_i,
    input  logic            write_i,
    input  mem_pkg::addr_t  addr_i,
    input  mem_pkg::line_t  line_i,
    output mem_pkg::line_t  line_o,
    output logic            resp_o,
    output mem_pkg::addr_t  bmem_addr_o,
    output logic            bmem_read_o,
    output logic            bmem_write_o,
    output mem_pkg::burst_t bmem_wdata_o,
    input  mem_pkg::burst_t bmem_rdata_i,
    input  logic            bmem_resp_i
);
    import mem_pkg::*;

    localparam int BEAT_W = $clog2(BURSTS_PER_LINE);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,    // bursts on the bus
        S_DONE     // resp to the line side
    } state_e;

    state_e            state_q;
    logic [BEAT_W-1:0] beat_q;
    logic              is_read_q;
    logic              is_write_q;
    logic              last_beat;
    addr_t             addr_q;
    line_t             line_q;

    assign last_beat = bmem_resp_i && (beat_q == BEAT_W'(BURSTS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            beat_q <= '0;
            is_read_q <= 1'b0;
            is_write_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (read_i || write_i) begin
                        state_q <= S_BUSY;
                        beat_q <= '0;
                        is_read_q <= read_i;
                        is_write_q <= write_i;
                    end
                end
                S_BUSY: begin
                    if (bmem_resp_i) begin
                        beat_q <= beat_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // one right shift per beat serves both directions
    // writes send from the low end, reads fill from the high end
    always_ff @(posedge clk) begin
        if ((state_q == S_IDLE) && (read_i || write_i)) begin
            addr_q <= {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
            line_q <= line_i;
        end else if ((state_q == S_BUSY) && bmem_resp_i) begin
            line_q <= {bmem_rdata_i, line_q[LINE_W-1:BURST_W]};
        end
    end

    assign bmem_addr_o = addr_q;
    assign bmem_read_o = (state_q == S_BUSY) && is_read_q;
    assign bmem_write_o = (state_q == S_BUSY) && is_write_q;
    assign bmem_wdata_o = line_q[BURST_W-1:0];    // current beat

    assign line_o = line_q;
    assign resp_o = (state_q == S_DONE);

    bus_dir_excl: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_o && bmem_write_o));

endmodule

// File: hw/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
    parameter int ICACHE_INDEX_W = 3,
    parameter int DCACHE_INDEX_W = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    // port a, instruction side
    input  logic                       a_read_i,
    input  logic                       a_write_i,
    input  mem_pkg::addr_t             a_addr_i,
    input  logic [mem_pkg::MASK_W-1:0] a_wmask_i,
    input  mem_pkg::word_t             a_wdata_i,
    output mem_pkg::word_t             a_rdata_o,
    output logic                       a_resp_o,
    // port b, data side
    input  logic                       b_read_i,
    input  logic                       b_write_i,
    input  mem_pkg::addr_t             b_addr_i,
    input  logic [mem_pkg::MASK_W-1:0] b_wmask_i,
    input  mem_pkg::word_t             b_wdata_i,
    output mem_pkg::word_t             b_rdata_o,
    output logic                       b_resp_o,
    // external burst memory
    output mem_pkg::addr_t             bmem_addr_o,
    output logic                       bmem_read_o,
    output logic                       bmem_write_o,
    output mem_pkg::burst_t            bmem_wdata_o,
    input  mem_pkg::burst_t            bmem_rdata_i,
    input  logic                       bmem_resp_i
);
    import mem_pkg::*;

    logic  ic_read, ic_write, ic_resp;    // icache <-> arbiter
    addr_t ic_addr;
    line_t ic_wdata, ic_rdata;
    logic  dc_read, dc_write, dc_resp;    // dcache <-> arbiter
    addr_t dc_addr;
    line_t dc_wdata, dc_rdata;
    logic  pm_read, pm_write, pm_resp;    // arbiter <-> adaptor
    addr_t pm_addr;
    line_t pm_wdata, pm_rdata;

    l1_cache #(.INDEX_W(ICACHE_INDEX_W)) icache (
        .clk, .rst,
        .mem_read_i(a_read_i), .mem_write_i(a_write_i), .mem_addr_i(a_addr_i),
        .mem_wmask_i(a_wmask_i), .mem_wdata_i(a_wdata_i),
        .mem_rdata_o(a_rdata_o), .mem_resp_o(a_resp_o),
        .pmem_read_o(ic_read), .pmem_write_o(ic_write), .pmem_addr_o(ic_addr),
        .pmem_wdata_o(ic_wdata), .pmem_rdata_i(ic_rdata), .pmem_resp_i(ic_resp)
    );

    l1_cache #(.INDEX_W(DCACHE_INDEX_W)) dcache (
        .clk, .rst,
        .mem_read_i(b_read_i), .mem_write_i(b_write_i), .mem_addr_i(b_addr_i),
        .mem_wmask_i(b_wmask_i), .mem_wdata_i(b_wdata_i),
        .mem_rdata_o(b_rdata_o), .mem_resp_o(b_resp_o),
        .pmem_read_o(dc_read), .pmem_write_o(dc_write), .pmem_addr_o(dc_addr),
        .pmem_wdata_o(dc_wdata), .pmem_rdata_i(dc_rdata), .pmem_resp_i(dc_resp)
    );

    mem_arbiter arbiter (
        .clk, .rst,
        .a_read_i(ic_read), .a_write_i(ic_write), .a_addr_i(ic_addr),
        .a_wdata_i(ic_wdata), .a_rdata_o(ic_rdata), .a_resp_o(ic_resp),
        .b_read_i(dc_read), .b_write_i(dc_write), .b_addr_i(dc_addr),
        .b_wdata_i(dc_wdata), .b_rdata_o(dc_rdata), .b_resp_o(dc_resp),
        .pmem_read_o(pm_read), .pmem_write_o(pm_write), .pmem_addr_o(pm_addr),
        .pmem_wdata_o(pm_wdata), .pmem_rdata_i(pm_rdata), .pmem_resp_i(pm_resp)
    );

    cacheline_adaptor adaptor (
        .clk, .rst,
        .read_i(pm_read), .write_i(pm_write), .addr_i(pm_addr),
        .line_i(pm_wdata), .line_o(pm_rdata), .resp_o(pm_resp),
        .bmem_addr_o, .bmem_read_o, .bmem_write_o,
        .bmem_wdata_o, .bmem_rdata_i, .bmem_resp_i
    );

endmodule

// File: test/bmem_model.sv
`timescale 1ns/1ps

module bmem_model (
    input  logic            clk,
    input  mem_pkg::addr_t  addr_i,
    input  logic            read_i,
    input  logic            write_i,
    input  mem_pkg::burst_t wdata_i,
    output mem_pkg::burst_t rdata_o,
    output logic            resp_o
);
    import mem_pkg::*;

    localparam int MEM_WORDS = 1024;    // 4 KiB of 32-bit words

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] lfsr_q;
    logic [1:0]  delay;
    int          word_idx;

    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'(i * 4) ^ 32'h5a5a_0000;    // byte address xor pattern
        end
        lfsr_q = 32'h0e79_3c02;
        resp_o = 1'b0;
        rdata_o = '0;
        forever begin
            @(negedge clk);
            if (read_i || write_i) begin
                word_idx = int'(addr_i[11:2]);    // line aligned, wraps at 4 KiB
                for (int beat = 0; beat < BURSTS_PER_LINE; beat++) begin
                    // 0 to 3 idle cycles before each beat
                    lfsr_q = step_lfsr(lfsr_q);
                    delay[0] = lfsr_q[0];
                    lfsr_q = step_lfsr(lfsr_q);
                    delay[1] = lfsr_q[0];
                    repeat (delay) @(negedge clk);
                    if (write_i) begin
                        mem[word_idx] = wdata_i[31:0];
                        mem[word_idx + 1] = wdata_i[63:32];
                    end
                    rdata_o = {mem[word_idx + 1], mem[word_idx]};
                    resp_o = 1'b1;
                    @(negedge clk);
                    resp_o = 1'b0;
                    word_idx = word_idx + 2;
                end
            end
        end
    end

endmodule

// File: test/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int ACCESS_LIMIT = 200;    // per access, far above a dirty miss
    localparam int NUM_ACCESSES = 17;
    localparam int WORST_MISS = 80;       // writeback, fill and a wait for the other port
    localparam int WATCHDOG_CYCLES = NUM_ACCESSES * WORST_MISS + 640;
    localparam int MEM_WORDS = 1024;

    logic              clk;
    logic              rst;
    logic              a_read_i;
    logic              a_write_i;
    addr_t             a_addr_i;
    logic [MASK_W-1:0] a_wmask_i;
    word_t             a_wdata_i;
    word_t             a_rdata_o;
    logic              a_resp_o;
    logic              b_read_i;
    logic              b_write_i;
    addr_t             b_addr_i;
    logic [MASK_W-1:0] b_wmask_i;
    word_t             b_wdata_i;
    word_t             b_rdata_o;
    logic              b_resp_o;
    addr_t             bmem_addr_o;
    logic              bmem_read_o;
    logic              bmem_write_o;
    burst_t            bmem_wdata_o;
    burst_t            bmem_rdata_i;
    logic              bmem_resp_i;

    word_t       shadow [MEM_WORDS];
    logic [31:0] lfsr_q;
    int          errors = 0;
    int          read_beats = 0;
    burst_t      wr_beats [$];
    addr_t       wr_addrs [$];

    mem_subsystem dut (.*);

    bmem_model bmem (
        .clk    (clk),
        .addr_i (bmem_addr_o),
        .read_i (bmem_read_o),
        .write_i(bmem_write_o),
        .wdata_i(bmem_wdata_o),
        .rdata_o(bmem_rdata_i),
        .resp_o (bmem_resp_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // bus monitor
    always @(posedge clk) begin
        if (bmem_read_o && bmem_resp_i) begin
            read_beats <= read_beats + 1;
        end
        if (bmem_write_o && bmem_resp_i) begin
            wr_beats.push_back(bmem_wdata_o);
            wr_addrs.push_back(bmem_addr_o);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run did not finish within %0d cycles, %0d errors so far",
                 WATCHDOG_CYCLES, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = next_lfsr(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic word_t shadow_word(input addr_t addr);
        return shadow[addr[11:2]];
    endfunction

    task automatic merge_shadow(input addr_t addr, input logic [MASK_W-1:0] mask,
                                input word_t data);
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                shadow[addr[11:2]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic a_access(input logic wr, input addr_t addr, input logic [MASK_W-1:0] mask,
                            input word_t wdata, output word_t rdata, output int cycles);
        @(negedge clk);
        a_read_i = !wr;
        a_write_i = wr;
        a_addr_i = addr;
        a_wmask_i = mask;
        a_wdata_i = wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!a_resp_o && cycles < ACCESS_LIMIT);
        if (!a_resp_o) begin
            errors++;
            $display("ERROR %0t ns: port A access to %h never got a response", $time, addr);
        end
        rdata = a_rdata_o;
        @(negedge clk);    // held through the resp cycle
        a_read_i = 1'b0;
        a_write_i = 1'b0;
    endtask

    task automatic b_access(input logic wr, input addr_t addr, input logic [MASK_W-1:0] mask,
                            input word_t wdata, output word_t rdata, output int cycles);
        @(negedge clk);
        b_read_i = !wr;
        b_write_i = wr;
        b_addr_i = addr;
        b_wmask_i = mask;
        b_wdata_i = wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!b_resp_o && cycles < ACCESS_LIMIT);
        if (!b_resp_o) begin
            errors++;
            $display("ERROR %0t ns: port B access to %h never got a response", $time, addr);
        end
        rdata = b_rdata_o;
        @(negedge clk);
        b_read_i = 1'b0;
        b_write_i = 1'b0;
    endtask

    task automatic reset_quiet();
        rst = 1'b1;
        for (int i = 0; i < RESET_CYCLES + 2; i++) begin
            @(negedge clk);
            check_value("a_resp_o", a_resp_o, 0);
            check_value("b_resp_o", b_resp_o, 0);
            check_value("bmem_read_o", bmem_read_o, 0);
            check_value("bmem_write_o", bmem_write_o, 0);
            if (i == RESET_CYCLES - 1) begin
                rst = 1'b0;    // two more cycles checked out of reset
            end
        end
    endtask

    task automatic read_miss_then_hit();
        word_t data;
        int    cycles;
        int    beats_before;
        a_access(1'b0, 32'h100, '0, '0, data, cycles);
        check_value("a_rdata_o", data, shadow_word(32'h100));
        beats_before = read_beats;
        a_access(1'b0, 32'h104, '0, '0, data, cycles);    // same line
        check_value("a_rdata_o", data, shadow_word(32'h104));
        check_value("a_resp_o hit latency", cycles, 1);
        check_value("bmem read beats", read_beats, beats_before);
    endtask

    task automatic masked_writes();
        logic [MASK_W-1:0] masks [5] = '{4'b0001, 4'b0110, 4'b1000, 4'b1111, 4'b1010};
        addr_t             addrs [5] = '{32'h400, 32'h404, 32'h404, 32'h40c, 32'h41c};
        word_t             data;
        word_t             rdata;
        int                cycles;
        for (int i = 0; i < 5; i++) begin
            draw_bits(32, data);
            b_access(1'b1, addrs[i], masks[i], data, rdata, cycles);
            merge_shadow(addrs[i], masks[i], data);
        end
        for (int i = 0; i < 5; i++) begin
            b_access(1'b0, addrs[i], '0, '0, rdata, cycles);
            check_value("b_rdata_o", rdata, shadow_word(addrs[i]));
        end
    endtask

    task automatic dirty_eviction();
        addr_t victim = 32'h540;
        addr_t other = 32'h640;    // same index, other tag
        addr_t line;
        word_t data;
        word_t rdata;
        int    cycles;
        line = victim & ~32'h1f;
        wr_beats.delete();
        wr_addrs.delete();
        draw_bits(32, data);
        b_access(1'b1, victim, 4'b1111, data, rdata, cycles);
        merge_shadow(victim, 4'b1111, data);
        b_access(1'b0, other, '0, '0, rdata, cycles);
        check_value("b_rdata_o", rdata, shadow_word(other));
        check_value("writeback beat count", wr_beats.size(), BURSTS_PER_LINE);
        for (int b = 0; b < wr_beats.size() && b < BURSTS_PER_LINE; b++) begin
            check_value("bmem_addr_o", wr_addrs[b], line);
            check_value("bmem_wdata_o", wr_beats[b],
                        {shadow_word(line + 8 * b + 4), shadow_word(line + 8 * b)});
        end
        b_access(1'b0, victim, '0, '0, rdata, cycles);
        check_value("b_rdata_o", rdata, shadow_word(victim));
    endtask

    task automatic port_contention();
        word_t a_data;
        word_t b_data;
        int    a_cycles;
        int    b_cycles;
        fork
            a_access(1'b0, 32'h800, '0, '0, a_data, a_cycles);
            b_access(1'b0, 32'ha20, '0, '0, b_data, b_cycles);
        join
        check_value("a_rdata_o", a_data, shadow_word(32'h800));
        check_value("b_rdata_o", b_data, shadow_word(32'ha20));
        check_value("b_resp_o before a_resp_o", b_cycles < a_cycles, 1);
    endtask

    initial begin
        lfsr_q = 32'h0e79_3c02;
        rst = 1'b1;
        a_read_i = 1'b0;
        a_write_i = 1'b0;
        a_addr_i = '0;
        a_wmask_i = '0;
        a_wdata_i = '0;
        b_read_i = 1'b0;
        b_write_i = 1'b0;
        b_addr_i = '0;
        b_wmask_i = '0;
        b_wdata_i = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = 32'(i * 4) ^ 32'h5a5a_0000;
        end
        reset_quiet();
        read_miss_then_hit();
        masked_writes();
        dirty_eviction();
        port_contention();
        repeat (4) @(negedge clk);
        $display("run complete: %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
common/mem_pkg.sv
cache/cache_arrays.sv
cache/l1_cache.sv
hw/mem_arbiter.sv
hw/cacheline_adaptor.sv
hw/mem_subsystem.sv
test/bmem_model.sv
test/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - common/mem_pkg.sv
  - cache/cache_arrays.sv
  - cache/l1_cache.sv
  - hw/mem_arbiter.sv
  - hw/cacheline_adaptor.sv
  - hw/mem_subsystem.sv
  - target: test
    files:
      - test/bmem_model.sv
      - test/tb_mem_subsystem.sv
